// File: design/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [25:0] inst_index_t;
	typedef logic [5:0] funct_t;
	// widest PC the stage structs can carry
	typedef logic [15:0] pc_max_t;

	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j = 6'h02,
		op_jal = 6'h03,
		op_beq = 6'h04,
		op_bne = 6'h05,
		op_addi = 6'h08,
		op_in = 6'h3c,
		op_out = 6'h3d,
		op_halt = 6'h3f
	} opcode_t;

	localparam funct_t funct_jr = 6'h08;
	localparam funct_t funct_add = 6'h20;
	localparam funct_t funct_sub = 6'h22;
	localparam funct_t funct_and = 6'h24;
	localparam funct_t funct_or = 6'h25;
	localparam funct_t funct_slt = 6'h2a;

	// jal destination
	localparam reg_addr_t link_reg = 5'd31;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_t;

	typedef enum logic [1:0] {
		br_next = 2'b00,
		br_cond = 2'b01,
		br_jump = 2'b10,
		br_reg = 2'b11
	} branch_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_link,
		wb_input
	} wb_src_t;

	typedef struct packed {
		alu_op_t alu_op;
		word_t a;
		word_t b;
		word_t register_data;
		reg_addr_t rd;
		logic reg_write;
		wb_src_t wb_src;
		branch_t branch;
		logic branch_eq;
		logic out_en;
		inst_index_t inst_index;
		pc_max_t pc1;
		pc_max_t pc2;
	} decode_out_t;

	typedef struct packed {
		word_t alu_result;
		word_t register_data;
		reg_addr_t rd;
		logic reg_write;
		wb_src_t wb_src;
		branch_t branch;
		inst_index_t inst_index;
		pc_max_t pc1;
		pc_max_t pc2;
	} execute_out_t;

endpackage

// File: design/register_file.sv
module register_file import cpu_pkg::*; (
	input logic CLK,
	input logic reset,
	input reg_addr_t rs_addr,
	input reg_addr_t rt_addr,
	input logic we,
	input reg_addr_t wd_addr,
	input word_t wd,
	output word_t rs_data,
	output word_t rt_data
);
	word_t regs [32];

	// r0 is never written, so it stays zero after reset
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wd_addr != '0) begin
			regs[wd_addr] <= wd;
		end
	end

	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

// File: design/pc_generator.sv
module pc_generator import cpu_pkg::*; #(
	parameter int INST_MEM_WIDTH = 6
) (
	input logic CLK,
	input logic reset,
	input branch_t branch,
	input logic [INST_MEM_WIDTH-1:0] register_data,
	input logic [INST_MEM_WIDTH-1:0] inst_index,
	input logic [INST_MEM_WIDTH-1:0] pc2,
	input logic [INST_MEM_WIDTH-1:0] pc1,
	input logic pc_enable,
	output logic [INST_MEM_WIDTH-1:0] pc
);
	logic [INST_MEM_WIDTH-1:0] pc_new;

	always_comb begin
		case (branch)
		br_next: pc_new = pc1;
		br_cond: pc_new = pc2;
		br_jump: pc_new = inst_index;
		br_reg: pc_new = register_data;
		default: pc_new = pc1;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset)
			pc <= '0;
		else if (pc_enable)
			pc <= pc_new;
	end

endmodule

// File: design/register_write.sv
module register_write import cpu_pkg::*; #(
	parameter int INST_MEM_WIDTH = 6
) (
	input logic CLK,
	input logic reset,
	input logic distinct,
	input wb_src_t wb_src,
	input word_t alu_result,
	input logic [INST_MEM_WIDTH-1:0] pc1,
	input word_t input_data,
	input logic input_ready,
	output logic input_taken,
	output logic pc_enable,
	output word_t data
);
	typedef enum logic {
		rw_idle,
		rw_wait
	} state_t;

	state_t state;
	logic take;

	assign take = state == rw_wait && input_ready;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= rw_idle;
			pc_enable <= 1'b0;
			input_taken <= 1'b0;
		end else begin
			pc_enable <= (distinct && wb_src != wb_input) || take;
			input_taken <= take;
			if (distinct && wb_src == wb_input)
				state <= rw_wait;
			else if (take)
				state <= rw_idle;
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			data <= input_data;
		end else if (distinct) begin
			case (wb_src)
			wb_link: data <= word_t'(pc1);
			default: data <= alu_result;
			endcase
		end
	end

endmodule

// File: design/instruction_fetch.sv
module instruction_fetch import cpu_pkg::*; #(
	parameter int INST_MEM_WIDTH = 6
) (
	input logic CLK,
	input logic reset,
	input logic prog_we,
	input logic [INST_MEM_WIDTH-1:0] prog_addr,
	input word_t prog_data,
	input logic start,
	input logic distinct,
	input logic [INST_MEM_WIDTH-1:0] pc,
	output logic distinct_next,
	output word_t instruction,
	output logic [INST_MEM_WIDTH-1:0] pc_fetched
);
	word_t inst_mem [2**INST_MEM_WIDTH];
	logic fetch;

	// first fetch on start, then on each returned strobe
	assign fetch = start || distinct;

	always_ff @(posedge CLK) begin
		if (prog_we)
			inst_mem[prog_addr] <= prog_data;
	end

	always_ff @(posedge CLK) begin
		if (reset)
			distinct_next <= 1'b0;
		else
			distinct_next <= fetch;
	end

	always_ff @(posedge CLK) begin
		if (fetch) begin
			instruction <= inst_mem[pc];
			pc_fetched <= pc;
		end
	end

endmodule

// File: design/instruction_decode.sv
module instruction_decode import cpu_pkg::*; #(
	parameter int INST_MEM_WIDTH = 6
) (
	input logic CLK,
	input logic reset,
	input logic distinct,
	input word_t instruction,
	input logic [INST_MEM_WIDTH-1:0] pc,
	output reg_addr_t rs_addr,
	output reg_addr_t rt_addr,
	input word_t rs_data,
	input word_t rt_data,
	output logic distinct_next,
	output decode_out_t decoded,
	output logic halt
);
	opcode_t opcode;
	funct_t funct;
	reg_addr_t rd_field;
	word_t imm_ext;
	logic use_imm;
	logic is_halt;
	logic [INST_MEM_WIDTH-1:0] pc1;
	logic [INST_MEM_WIDTH-1:0] pc2;
	decode_out_t ctrl;

	assign opcode = opcode_t'(instruction[31:26]);
	assign rs_addr = instruction[25:21];
	assign rt_addr = instruction[20:16];
	assign rd_field = instruction[15:11];
	assign funct = instruction[5:0];
	assign imm_ext = {{16{instruction[15]}}, instruction[15:0]};
	assign pc1 = pc + 1'b1;
	// word offset relative to the next instruction
	assign pc2 = pc1 + imm_ext[INST_MEM_WIDTH-1:0];

	always_comb begin
		ctrl = '0;
		use_imm = 1'b0;
		is_halt = 1'b0;
		ctrl.alu_op = alu_add;
		ctrl.wb_src = wb_alu;
		ctrl.branch = br_next;
		ctrl.rd = rd_field;
		case (opcode)
		op_rtype: begin
			ctrl.reg_write = 1'b1;
			case (funct)
			funct_add: ctrl.alu_op = alu_add;
			funct_sub: ctrl.alu_op = alu_sub;
			funct_and: ctrl.alu_op = alu_and;
			funct_or: ctrl.alu_op = alu_or;
			funct_slt: ctrl.alu_op = alu_slt;
			funct_jr: begin
				ctrl.reg_write = 1'b0;
				ctrl.branch = br_reg;
			end
			default: ctrl.reg_write = 1'b0;
			endcase
		end
		op_addi: begin
			use_imm = 1'b1;
			ctrl.rd = rt_addr;
			ctrl.reg_write = 1'b1;
		end
		op_beq: begin
			ctrl.branch = br_cond;
			ctrl.branch_eq = 1'b1;
		end
		op_bne: ctrl.branch = br_cond;
		op_j: ctrl.branch = br_jump;
		op_jal: begin
			ctrl.branch = br_jump;
			ctrl.rd = link_reg;
			ctrl.reg_write = 1'b1;
			ctrl.wb_src = wb_link;
		end
		op_in: begin
			ctrl.reg_write = 1'b1;
			ctrl.wb_src = wb_input;
		end
		op_out: ctrl.out_en = 1'b1;
		op_halt: is_halt = 1'b1;
		default: ;
		endcase
		ctrl.a = rs_data;
		ctrl.b = use_imm ? imm_ext : rt_data;
		ctrl.register_data = rs_data;
		ctrl.inst_index = instruction[25:0];
		ctrl.pc1 = pc_max_t'(pc1);
		ctrl.pc2 = pc_max_t'(pc2);
	end

	// halt is sticky and stops the strobe here
	always_ff @(posedge CLK) begin
		if (reset) begin
			distinct_next <= 1'b0;
			halt <= 1'b0;
		end else begin
			distinct_next <= distinct && !is_halt;
			if (distinct && is_halt)
				halt <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (distinct)
			decoded <= ctrl;
	end

endmodule

// File: design/alu_execute.sv
module alu_execute import cpu_pkg::*; (
	input logic CLK,
	input logic reset,
	input logic distinct,
	input decode_out_t decoded,
	output logic distinct_next,
	output execute_out_t executed,
	output logic out_valid,
	output word_t out_data
);
	word_t result;
	logic equal;
	branch_t branch_resolved;

	always_comb begin
		case (decoded.alu_op)
		alu_add: result = decoded.a + decoded.b;
		alu_sub: result = decoded.a - decoded.b;
		alu_and: result = decoded.a & decoded.b;
		alu_or: result = decoded.a | decoded.b;
		alu_slt: result = word_t'($signed(decoded.a) < $signed(decoded.b));
		default: result = decoded.a + decoded.b;
		endcase
	end

	assign equal = decoded.a == decoded.b;

	// not taken falls back to pc+1
	always_comb begin
		branch_resolved = decoded.branch;
		if (decoded.branch == br_cond && equal != decoded.branch_eq)
			branch_resolved = br_next;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			distinct_next <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			distinct_next <= distinct;
			out_valid <= distinct && decoded.out_en;
		end
	end

	always_ff @(posedge CLK) begin
		if (distinct) begin
			executed.alu_result <= result;
			executed.register_data <= decoded.register_data;
			executed.rd <= decoded.rd;
			executed.reg_write <= decoded.reg_write;
			executed.wb_src <= decoded.wb_src;
			executed.branch <= branch_resolved;
			executed.inst_index <= decoded.inst_index;
			executed.pc1 <= decoded.pc1;
			executed.pc2 <= decoded.pc2;
			out_data <= decoded.register_data;
		end
	end

endmodule

// File: design/write_buffer_pc_generate.sv
module write_buffer_pc_generate import cpu_pkg::*; #(
	parameter int INST_MEM_WIDTH = 6
) (
	input logic CLK,
	input logic reset,
	input logic distinct,
	input execute_out_t executed,
	input logic input_ready,
	input word_t input_data,
	output logic distinct_next,
	output logic RegWrite_next,
	output reg_addr_t rd_next,
	output word_t data,
	output logic input_taken,
	output logic [INST_MEM_WIDTH-1:0] pc_generated,
	output logic [INST_MEM_WIDTH-1:0] retire_pc
);
	typedef enum logic {
		st_capture,
		st_release
	} state_t;

	state_t state;
	execute_out_t buffered;
	logic pc_enable;

	// sees the strobe together with the capture
	register_write #(
		.INST_MEM_WIDTH(INST_MEM_WIDTH)
	) register_write_i (
		.CLK(CLK),
		.reset(reset),
		.distinct(distinct),
		.wb_src(executed.wb_src),
		.alu_result(executed.alu_result),
		.pc1(executed.pc1[INST_MEM_WIDTH-1:0]),
		.input_data(input_data),
		.input_ready(input_ready),
		.input_taken(input_taken),
		.pc_enable(pc_enable),
		.data(data)
	);

	pc_generator #(
		.INST_MEM_WIDTH(INST_MEM_WIDTH)
	) pc_generator_i (
		.CLK(CLK),
		.reset(reset),
		.branch(buffered.branch),
		.register_data(buffered.register_data[INST_MEM_WIDTH-1:0]),
		.inst_index(buffered.inst_index[INST_MEM_WIDTH-1:0]),
		.pc2(buffered.pc2[INST_MEM_WIDTH-1:0]),
		.pc1(buffered.pc1[INST_MEM_WIDTH-1:0]),
		.pc_enable(pc_enable),
		.pc(pc_generated)
	);

	// write port is live only in the commit cycle
	assign RegWrite_next = pc_enable && buffered.reg_write;
	assign rd_next = buffered.rd;

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= st_capture;
			distinct_next <= 1'b0;
		end else begin
			distinct_next <= 1'b0;
			case (state)
			st_capture: begin
				if (distinct)
					state <= st_release;
			end
			st_release: begin
				if (pc_enable) begin
					state <= st_capture;
					distinct_next <= 1'b1;
				end
			end
			default: state <= st_capture;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == st_capture && distinct)
			buffered <= executed;
		// old pc, sampled as the new one loads
		if (pc_enable)
			retire_pc <= pc_generated;
	end

endmodule

// File: design/cpu_top.sv
module cpu_top import cpu_pkg::*; #(
	parameter int INST_MEM_WIDTH = 6
) (
	input logic CLK,
	input logic reset,
	input logic prog_we,
	input logic [INST_MEM_WIDTH-1:0] prog_addr,
	input word_t prog_data,
	input logic start,
	input logic input_ready,
	input word_t input_data,
	output logic input_taken,
	output logic out_valid,
	output word_t out_data,
	output logic retire_valid,
	output logic [INST_MEM_WIDTH-1:0] retire_pc,
	output logic halted
);
	logic fetch_distinct;
	logic decode_distinct;
	logic execute_distinct;
	word_t instruction;
	logic [INST_MEM_WIDTH-1:0] pc_fetched;
	logic [INST_MEM_WIDTH-1:0] pc;
	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	word_t rs_data;
	word_t rt_data;
	decode_out_t decoded;
	execute_out_t executed;
	logic reg_write;
	reg_addr_t rd;
	word_t wb_data;

	// retire strobe doubles as the next fetch trigger
	instruction_fetch #(
		.INST_MEM_WIDTH(INST_MEM_WIDTH)
	) instruction_fetch_i (
		.CLK(CLK),
		.reset(reset),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.start(start),
		.distinct(retire_valid),
		.pc(pc),
		.distinct_next(fetch_distinct),
		.instruction(instruction),
		.pc_fetched(pc_fetched)
	);

	instruction_decode #(
		.INST_MEM_WIDTH(INST_MEM_WIDTH)
	) instruction_decode_i (
		.CLK(CLK),
		.reset(reset),
		.distinct(fetch_distinct),
		.instruction(instruction),
		.pc(pc_fetched),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.distinct_next(decode_distinct),
		.decoded(decoded),
		.halt(halted)
	);

	alu_execute alu_execute_i (
		.CLK(CLK),
		.reset(reset),
		.distinct(decode_distinct),
		.decoded(decoded),
		.distinct_next(execute_distinct),
		.executed(executed),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	write_buffer_pc_generate #(
		.INST_MEM_WIDTH(INST_MEM_WIDTH)
	) write_buffer_pc_generate_i (
		.CLK(CLK),
		.reset(reset),
		.distinct(execute_distinct),
		.executed(executed),
		.input_ready(input_ready),
		.input_data(input_data),
		.distinct_next(retire_valid),
		.RegWrite_next(reg_write),
		.rd_next(rd),
		.data(wb_data),
		.input_taken(input_taken),
		.pc_generated(pc),
		.retire_pc(retire_pc)
	);

	register_file register_file_i (
		.CLK(CLK),
		.reset(reset),
		.rs_addr(rs_addr),
		.rt_addr(rt_addr),
		.we(reg_write),
		.wd_addr(rd),
		.wd(wb_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

endmodule

// File: testbench/cpu_model.svh
// instruction-set model of the core, run ahead of each program
word_t prog_image [64];
int prog_len;
word_t model_regs [32];
logic [5:0] exp_retire [$];
word_t exp_out [$];
word_t model_inputs [$];

function automatic word_t rtype_inst(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd, funct_t funct);
	return {6'h00, rs, rt, rd, 5'd0, funct};
endfunction

function automatic word_t itype_inst(opcode_t op, reg_addr_t rs, reg_addr_t rt, logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic word_t jtype_inst(opcode_t op, inst_index_t index);
	return {op, index};
endfunction

task automatic append_inst(word_t inst);
	prog_image[prog_len] = inst;
	prog_len++;
endtask

// unused words hold halt, tagged with their own address
task automatic clear_program();
	for (int i = 0; i < 64; i++)
		prog_image[i] = {op_halt, 20'd0, 6'(i)};
	prog_len = 0;
	model_inputs.delete();
endtask

task automatic set_reg(reg_addr_t r, word_t v);
	if (r != 5'd0)
		model_regs[r] = v;
endtask

task automatic run_model();
	logic [5:0] pc;
	logic [5:0] next_pc;
	word_t inst;
	word_t a;
	word_t b;
	word_t sext;
	reg_addr_t rd;
	word_t inputs [$];
	logic done;
	for (int i = 0; i < 32; i++)
		model_regs[i] = '0;
	exp_retire.delete();
	exp_out.delete();
	inputs = model_inputs;
	pc = '0;
	done = 1'b0;
	for (int steps = 0; steps < 500 && !done; steps++) begin
		inst = prog_image[pc];
		a = model_regs[inst[25:21]];
		b = model_regs[inst[20:16]];
		rd = inst[15:11];
		sext = {{16{inst[15]}}, inst[15:0]};
		next_pc = pc + 6'd1;
		case (opcode_t'(inst[31:26]))
		op_rtype: begin
			case (inst[5:0])
			funct_add: set_reg(rd, a + b);
			funct_sub: set_reg(rd, a - b);
			funct_and: set_reg(rd, a & b);
			funct_or: set_reg(rd, a | b);
			funct_slt: set_reg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
			funct_jr: next_pc = a[5:0];
			default: ;
			endcase
		end
		op_addi: set_reg(inst[20:16], a + sext);
		op_beq: if (a == b) next_pc = pc + 6'd1 + inst[5:0];
		op_bne: if (a != b) next_pc = pc + 6'd1 + inst[5:0];
		op_j: next_pc = inst[5:0];
		op_jal: begin
			set_reg(link_reg, word_t'(pc + 6'd1));
			next_pc = inst[5:0];
		end
		op_in: set_reg(rd, inputs.pop_front());
		op_out: exp_out.push_back(a);
		op_halt: done = 1'b1;
		default: ;
		endcase
		if (!done)
			exp_retire.push_back(pc);
		pc = next_pc;
	end
endtask

// File: testbench/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();
	logic CLK;
	logic reset;
	logic prog_we;
	logic [5:0] prog_addr;
	word_t prog_data;
	logic start;
	logic input_ready;
	word_t input_data;
	logic input_taken;
	logic out_valid;
	word_t out_data;
	logic retire_valid;
	logic [5:0] retire_pc;
	logic halted;

	int value_errors;
	int protocol_errors;
	int timeouts;
	int cycle;
	int last_retire;
	int takes_since_retire;
	string test_name;
	logic [31:0] lfsr_state;
	logic [5:0] exp_pc;
	word_t exp_word;
	word_t input_words [$];

	`include "cpu_model.svh"

	cpu_top #(
		.INST_MEM_WIDTH(6)
	) dut_i (
		.CLK(CLK),
		.reset(reset),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.start(start),
		.input_ready(input_ready),
		.input_data(input_data),
		.input_taken(input_taken),
		.out_valid(out_valid),
		.out_data(out_data),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.halted(halted)
	);

	always #4 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle <= cycle + 1;
	end

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	// strobes are single-cycle pulses
	assert property (@(posedge CLK) disable iff (reset) out_valid |=> !out_valid)
		else begin
			protocol_errors++;
			$display("out_valid stayed high for more than one cycle");
		end
	assert property (@(posedge CLK) disable iff (reset) retire_valid |=> !retire_valid)
		else begin
			protocol_errors++;
			$display("retire_valid stayed high for more than one cycle");
		end
	assert property (@(posedge CLK) disable iff (reset) input_taken |=> !input_taken)
		else begin
			protocol_errors++;
			$display("input_taken stayed high for more than one cycle");
		end
	assert property (@(posedge CLK) disable iff (reset) input_taken |-> $past(input_ready))
		else begin
			protocol_errors++;
			$display("input_taken pulsed without input_ready");
		end
	assert property (@(posedge CLK) disable iff (reset) halted |=> halted)
		else begin
			protocol_errors++;
			$display("halted dropped without a reset");
		end
	assert property (@(posedge CLK) reset |=> !(out_valid || retire_valid || input_taken || halted))
		else begin
			protocol_errors++;
			$display("a strobe or halted is high during reset");
		end

	// outputs compared mid-cycle against the model queues
	always @(negedge CLK) begin
		if (!reset) begin
			if (input_taken)
				takes_since_retire++;
			if (out_valid) begin
				if (exp_out.size() == 0) begin
					protocol_errors++;
					$display("%s: out_valid pulsed with no out expected", test_name);
				end else begin
					exp_word = exp_out.pop_front();
					assert (out_data == exp_word)
						else begin
							value_errors++;
							$display("ERROR %s: out_data expected %h, actual %h",
								test_name, exp_word, out_data);
						end
				end
			end
			if (retire_valid) begin
				if (exp_retire.size() == 0) begin
					protocol_errors++;
					$display("%s: retire_valid pulsed with no retire expected", test_name);
				end else begin
					exp_pc = exp_retire.pop_front();
					assert (retire_pc == exp_pc)
						else begin
							value_errors++;
							$display("ERROR %s: retire_pc expected %0d, actual %0d",
								test_name, exp_pc, retire_pc);
						end
				end
				if (prog_image[retire_pc][31:26] == op_in) begin
					assert (takes_since_retire == 1)
						else begin
							value_errors++;
							$display("ERROR %s: input_taken count expected 1, actual %0d",
								test_name, takes_since_retire);
						end
				end else begin
					assert (takes_since_retire == 0)
						else begin
							value_errors++;
							$display("ERROR %s: input_taken count expected 0, actual %0d",
								test_name, takes_since_retire);
						end
					if (last_retire >= 0) begin
						assert (cycle - last_retire == 5)
							else begin
								value_errors++;
								$display("ERROR %s: retire spacing expected 5, actual %0d",
									test_name, cycle - last_retire);
							end
					end
				end
				takes_since_retire = 0;
				last_retire = cycle;
			end
		end
	end

	task automatic apply_reset();
		reset = 1'b1;
		repeat (10) @(negedge CLK);
		reset = 1'b0;
	endtask

	task automatic load_program();
		for (int i = 0; i < 64; i++) begin
			@(negedge CLK);
			prog_we = 1'b1;
			prog_addr = 6'(i);
			prog_data = prog_image[i];
		end
		@(negedge CLK);
		prog_we = 1'b0;
	endtask

	task automatic wait_halted(int limit);
		int n;
		n = 0;
		while (!halted && n < limit) begin
			@(negedge CLK);
			n++;
		end
		if (!halted) begin
			timeouts++;
			$display("%s: core did not halt within %0d cycles", test_name, limit);
		end
	endtask

	// random delay before each word is offered
	task automatic drive_inputs();
		int n;
		while (input_words.size() > 0) begin
			repeat (random_bits(5)) @(negedge CLK);
			input_ready = 1'b1;
			input_data = input_words.pop_front();
			n = 0;
			do begin
				@(negedge CLK);
				n++;
			end while (!input_taken && n < 300);
			input_ready = 1'b0;
			input_data = random_bits(32);
			if (!input_taken) begin
				timeouts++;
				$display("%s: input word was never taken", test_name);
				return;
			end
		end
	endtask

	task automatic run_test(string name);
		test_name = name;
		run_model();
		apply_reset();
		load_program();
		last_retire = -1;
		takes_since_retire = 0;
		input_words = model_inputs;
		@(negedge CLK);
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
		fork
			wait_halted(3000);
			drive_inputs();
		join
		// nothing may retire or go out after halt
		repeat (40) @(negedge CLK);
		if (exp_retire.size() != 0 || exp_out.size() != 0) begin
			protocol_errors++;
			$display("%s: %0d retires and %0d outs never appeared",
				test_name, exp_retire.size(), exp_out.size());
		end
	endtask

	task automatic build_alu_program();
		funct_t ops [5];
		ops = '{funct_add, funct_sub, funct_and, funct_or, funct_slt};
		clear_program();
		for (int r = 0; r < 2; r++) begin
			append_inst(itype_inst(op_addi, 5'd0, 5'd1, 16'(random_bits(16))));
			append_inst(itype_inst(op_addi, 5'd0, 5'd2, 16'(random_bits(16))));
			foreach (ops[k]) begin
				append_inst(rtype_inst(5'd1, 5'd2, 5'd3, ops[k]));
				append_inst(itype_inst(op_out, 5'd3, 5'd0, 16'd0));
			end
			append_inst(rtype_inst(5'd2, 5'd1, 5'd3, funct_slt));
			append_inst(itype_inst(op_out, 5'd3, 5'd0, 16'd0));
			append_inst(rtype_inst(5'd1, 5'd2, 5'd0, funct_add));
			append_inst(itype_inst(op_out, 5'd0, 5'd0, 16'd0));
		end
		append_inst(jtype_inst(op_halt, 26'd0));
	endtask

	task automatic build_branch_program();
		clear_program();
		append_inst(itype_inst(op_addi, 5'd0, 5'd1, 16'd5));
		append_inst(itype_inst(op_addi, 5'd0, 5'd2, 16'd5));
		append_inst(itype_inst(op_addi, 5'd0, 5'd3, 16'd7));
		append_inst(itype_inst(op_beq, 5'd1, 5'd2, 16'd1));
		append_inst(itype_inst(op_out, 5'd1, 5'd0, 16'd0));
		append_inst(itype_inst(op_beq, 5'd1, 5'd3, 16'd1));
		append_inst(itype_inst(op_out, 5'd3, 5'd0, 16'd0));
		append_inst(itype_inst(op_bne, 5'd1, 5'd3, 16'd1));
		append_inst(itype_inst(op_out, 5'd1, 5'd0, 16'd0));
		append_inst(itype_inst(op_bne, 5'd1, 5'd2, 16'd1));
		append_inst(itype_inst(op_out, 5'd2, 5'd0, 16'd0));
		// count-down loop with a backward bne
		append_inst(itype_inst(op_addi, 5'd0, 5'd4, 16'd3));
		append_inst(itype_inst(op_addi, 5'd4, 5'd4, 16'hffff));
		append_inst(itype_inst(op_out, 5'd4, 5'd0, 16'd0));
		append_inst(itype_inst(op_bne, 5'd4, 5'd0, 16'hfffd));
		append_inst(jtype_inst(op_halt, 26'd0));
	endtask

	task automatic build_jump_program();
		clear_program();
		append_inst(jtype_inst(op_j, 26'd3));
		append_inst(itype_inst(op_out, 5'd0, 5'd0, 16'd0));
		append_inst(jtype_inst(op_halt, 26'd0));
		append_inst(jtype_inst(op_jal, 26'd7));
		append_inst(itype_inst(op_out, 5'd31, 5'd0, 16'd0));
		append_inst(itype_inst(op_addi, 5'd0, 5'd6, 16'd9));
		append_inst(jtype_inst(op_halt, 26'd0));
		// subroutine
		append_inst(itype_inst(op_out, 5'd31, 5'd0, 16'd0));
		append_inst(rtype_inst(5'd31, 5'd0, 5'd0, funct_jr));
	endtask

	task automatic build_input_program();
		clear_program();
		for (int k = 0; k < 3; k++) begin
			append_inst(itype_inst(op_in, 5'd0, 5'd0, {5'd7, 11'd0}));
			append_inst(itype_inst(op_in, 5'd0, 5'd0, {5'd8, 11'd0}));
			append_inst(rtype_inst(5'd7, 5'd8, 5'd9, funct_add));
			append_inst(itype_inst(op_out, 5'd7, 5'd0, 16'd0));
			append_inst(itype_inst(op_out, 5'd9, 5'd0, 16'd0));
		end
		append_inst(itype_inst(op_in, 5'd0, 5'd0, {5'd0, 11'd0}));
		append_inst(itype_inst(op_out, 5'd0, 5'd0, 16'd0));
		append_inst(jtype_inst(op_halt, 26'd0));
		for (int k = 0; k < 7; k++)
			model_inputs.push_back(random_bits(32));
	endtask

	initial begin
		CLK = 1'b0;
		reset = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		start = 1'b0;
		input_ready = 1'b0;
		input_data = '0;
		cycle = 0;
		value_errors = 0;
		protocol_errors = 0;
		timeouts = 0;
		last_retire = -1;
		takes_since_retire = 0;
		lfsr_state = 32'hb2cd_67cf;
		test_name = "reset";

		build_alu_program();
		run_test("alu");
		build_branch_program();
		run_test("branch");
		build_jump_program();
		run_test("jump");
		build_input_program();
		run_test("input");

		$display("errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeouts);
		if (value_errors + protocol_errors + timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+testbench
design/cpu_pkg.sv
design/register_file.sv
design/pc_generator.sv
design/register_write.sv
design/instruction_fetch.sv
design/instruction_decode.sv
design/alu_execute.sv
design/write_buffer_pc_generate.sv
design/cpu_top.sv
testbench/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpu_tb -f verilog.f -o Vcpu_tb

./obj_dir/Vcpu_tb | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
